// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = platformer_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/coin_tracker.sv ====
/* coin table with collected flags, score counter
   and the coin hit test for the scanned pixel */
`timescale 1ns/1ps
`include "game_macros.svh"

module coin_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  game_pkg::coord_t     player_x,
    input  game_pkg::coord_t     player_y,
    input  game_pkg::coord_t     hcount,
    input  game_pkg::coord_t     vcount,
    output game_pkg::score_t     score,
    output game_pkg::coin_mask_t collected,
    output logic                 coin_hit
);

    localparam game_pkg::coord_t COIN_X [`NUM_COINS] =
        '{`COIN0_X, `COIN1_X, `COIN2_X, `COIN3_X};
    localparam game_pkg::coord_t COIN_Y [`NUM_COINS] =
        '{`COIN0_Y, `COIN1_Y, `COIN2_Y, `COIN3_Y};

    logic [10:0] left_edge;
    logic [10:0] right_edge;
    logic [10:0] top_edge;
    logic [10:0] bottom_edge;
    // uncollected coins the player overlaps this cycle
    game_pkg::coin_mask_t touch;

    assign left_edge   = {1'b0, player_x};
    assign right_edge  = left_edge + `CHAR_WIDTH;
    assign top_edge    = {1'b0, player_y};
    assign bottom_edge = top_edge + `CHAR_HEIGHT;

    always_comb begin
        touch    = '0;
        coin_hit = 1'b0;
        for (int i = 0; i < `NUM_COINS; i++) begin
            if (!collected[i] &&
                (right_edge > COIN_X[i]) && (left_edge < COIN_X[i] + `COIN_SIZE) &&
                (bottom_edge > COIN_Y[i]) && (top_edge < COIN_Y[i] + `COIN_SIZE))
                touch[i] = 1'b1;
            // collected coins vanish from the scene
            if (!collected[i] &&
                (hcount >= COIN_X[i]) && (hcount < COIN_X[i] + `COIN_SIZE) &&
                (vcount >= COIN_Y[i]) && (vcount < COIN_Y[i] + `COIN_SIZE))
                coin_hit = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            collected <= '0;
            score     <= '0;
        end else begin
            collected <= collected | touch;
            score     <= score + game_pkg::score_t'($countones(touch));
        end
    end

    a_collected_sticky: assert property (@(posedge clk) disable iff (rst)
        ($past(collected) & ~collected) == '0);
    a_score_monotonic: assert property (@(posedge clk) disable iff (rst)
        score >= $past(score));

endmodule

// ==== logic/game_macros.svh ====
/* platformer engine constants
   colours, screen and player geometry, level layout and jump physics */
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// 12-bit rgb, four bits per channel
`define COLOR_BLACK     12'h000
`define COLOR_SKY       12'h7AF
`define COLOR_PLAYER    12'hF00
`define COLOR_GROUND    12'h0F0
`define COLOR_PLATFORM  12'hFFF
`define COLOR_COIN      12'hFF0

// horizontal play limits in scan coordinates
`define SCREEN_LEFT     10'd143
`define SCREEN_RIGHT    10'd734

// player block
`define CHAR_WIDTH      10'd32
`define CHAR_HEIGHT     10'd32
`define START_X         10'd300

// ground band, first and last row
`define GROUND_TOP      10'd492
`define GROUND_BOTTOM   10'd516
`define GROUND_STAND_Y  (`GROUND_TOP - `CHAR_HEIGHT)

// platforms are one tile thick
`define TILE_SIZE       10'd24
`define STAND_TOL       10'd10
`define NUM_PLATFORMS   4
`define PLAT0_X0        10'd500
`define PLAT0_X1        10'd540
`define PLAT0_Y         10'd400
`define PLAT1_X0        10'd250
`define PLAT1_X1        10'd280
`define PLAT1_Y         10'd300
`define PLAT2_X0        10'd600
`define PLAT2_X1        10'd640
`define PLAT2_Y         10'd400
`define PLAT3_X0        10'd378
`define PLAT3_X1        10'd450
`define PLAT3_Y         10'd350

// coins, top-left corners
`define NUM_COINS       4
`define COIN_SIZE       10'd16
`define COIN0_X         10'd300
`define COIN0_Y         10'd400
`define COIN1_X         10'd250
`define COIN1_Y         10'd284
`define COIN2_X         10'd600
`define COIN2_Y         10'd384
`define COIN3_X         10'd378
`define COIN3_Y         10'd334

// jump physics, pixels per physics tick
`define V_INIT          7'd15
`define GRAVITY         7'd1

`endif

// ==== logic/game_pkg.sv ====
/* shared types for the platformer engine */
`include "game_macros.svh"

package game_pkg;

    // rgb pixel, 4:4:4
    typedef logic [11:0] color_t;

    // scan counters and player position
    typedef logic [9:0] coord_t;

    // vertical speed, negative is upward
    typedef logic signed [6:0] velocity_t;

    // one bit per coin, set once collected
    typedef logic [`NUM_COINS-1:0] coin_mask_t;

    // coins collected so far
    typedef logic [15:0] score_t;

endpackage

// ==== logic/pixel_compositor.sv ====
/* two-stage pixel pipeline, layers player, ground, platforms,
   coins and sky into the output colour */
`timescale 1ns/1ps
`include "game_macros.svh"

module pixel_compositor (
    input  logic             clk,
    input  logic             rst,
    input  game_pkg::coord_t hcount,
    input  game_pkg::coord_t vcount,
    input  logic             bright,
    input  game_pkg::coord_t player_x,
    input  game_pkg::coord_t player_y,
    input  logic             plat_hit,
    input  logic             coin_hit,
    output game_pkg::color_t rgb
);

    logic player_hit;
    logic ground_hit;

    // stage 1 flags
    logic bright_q;
    logic player_q;
    logic ground_q;
    logic plat_q;
    logic coin_q;

    // widened sums keep the right and bottom edges exact
    assign player_hit = (hcount >= player_x) && ({1'b0, hcount} < {1'b0, player_x} + `CHAR_WIDTH) &&
                        (vcount >= player_y) && ({1'b0, vcount} < {1'b0, player_y} + `CHAR_HEIGHT);
    assign ground_hit = (vcount >= `GROUND_TOP) && (vcount <= `GROUND_BOTTOM);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bright_q <= 1'b0;
            player_q <= 1'b0;
            ground_q <= 1'b0;
            plat_q   <= 1'b0;
            coin_q   <= 1'b0;
        end else begin
            bright_q <= bright;
            player_q <= player_hit;
            ground_q <= ground_hit;
            plat_q   <= plat_hit;
            coin_q   <= coin_hit;
        end
    end

    // stage 2, front layer first
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rgb <= `COLOR_BLACK;
        else if (!bright_q)
            rgb <= `COLOR_BLACK;
        else if (player_q)
            rgb <= `COLOR_PLAYER;
        else if (ground_q)
            rgb <= `COLOR_GROUND;
        else if (plat_q)
            rgb <= `COLOR_PLATFORM;
        else if (coin_q)
            rgb <= `COLOR_COIN;
        else
            rgb <= `COLOR_SKY;
    end

endmodule

// ==== logic/platform_map.sv ====
/* platform table with player collision queries
   and the platform hit test for the scanned pixel */
`timescale 1ns/1ps
`include "game_macros.svh"

module platform_map (
    input  game_pkg::coord_t player_x,
    input  game_pkg::coord_t player_y,
    input  game_pkg::coord_t hcount,
    input  game_pkg::coord_t vcount,
    output logic             blocked_left,
    output logic             blocked_right,
    output logic             supported,
    output logic             headbutt,
    output logic             plat_hit,
    output game_pkg::coord_t support_y
);

    localparam game_pkg::coord_t PLAT_X0 [`NUM_PLATFORMS] =
        '{`PLAT0_X0, `PLAT1_X0, `PLAT2_X0, `PLAT3_X0};
    localparam game_pkg::coord_t PLAT_X1 [`NUM_PLATFORMS] =
        '{`PLAT0_X1, `PLAT1_X1, `PLAT2_X1, `PLAT3_X1};
    localparam game_pkg::coord_t PLAT_Y [`NUM_PLATFORMS] =
        '{`PLAT0_Y, `PLAT1_Y, `PLAT2_Y, `PLAT3_Y};

    // player edges one bit wider so the sums never wrap
    logic [10:0] left_edge;
    logic [10:0] top_edge;
    logic [10:0] bottom_edge;
    logic on_ground;
    logic on_plat;
    game_pkg::coord_t plat_top;

    assign left_edge   = {1'b0, player_x};
    assign top_edge    = {1'b0, player_y};
    assign bottom_edge = top_edge + `CHAR_HEIGHT;

    // either player edge strictly inside the platform span
    function automatic logic x_overlap(input logic [10:0] left, input int idx);
        logic [10:0] right;
        right = left + `CHAR_WIDTH;
        return ((right > PLAT_X0[idx]) && (right < PLAT_X1[idx])) ||
               ((left > PLAT_X0[idx]) && (left < PLAT_X1[idx]));
    endfunction

    always_comb begin
        blocked_left  = 1'b0;
        blocked_right = 1'b0;
        headbutt      = 1'b0;
        on_plat       = 1'b0;
        plat_top      = `GROUND_TOP;
        plat_hit      = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            // body rows overlap the tile rows, probe one pixel to each side
            if ((bottom_edge > PLAT_Y[i]) && (top_edge < PLAT_Y[i] + `TILE_SIZE)) begin
                if (x_overlap(left_edge - 11'd1, i))
                    blocked_left = 1'b1;
                if (x_overlap(left_edge + 11'd1, i))
                    blocked_right = 1'b1;
            end
            if (x_overlap(left_edge, i)) begin
                // feet just at or below the top surface
                if ((bottom_edge >= PLAT_Y[i]) && (bottom_edge <= PLAT_Y[i] + `STAND_TOL)) begin
                    on_plat  = 1'b1;
                    plat_top = PLAT_Y[i];
                end
                // head inside the tile from below
                if ((top_edge > PLAT_Y[i]) && (top_edge <= PLAT_Y[i] + `TILE_SIZE))
                    headbutt = 1'b1;
            end
            if ((hcount >= PLAT_X0[i]) && (hcount < PLAT_X1[i]) &&
                (vcount >= PLAT_Y[i]) && (vcount < PLAT_Y[i] + `TILE_SIZE))
                plat_hit = 1'b1;
        end
    end

    // ground wins over a platform match
    assign on_ground = bottom_edge >= `GROUND_TOP;
    assign supported = on_ground | on_plat;
    assign support_y = on_ground ? `GROUND_STAND_Y : plat_top - `CHAR_HEIGHT;

endmodule

// ==== logic/platformer_top.sv ====
/* platformer game engine top
   joins motion, platform map, coins and pixel compositor */
`timescale 1ns/1ps

module platformer_top #(
    parameter int move_div = 500000,
    parameter int phys_div = 1000000
) (
    input  logic             clk,
    input  logic             rst,
    input  game_pkg::coord_t hcount,
    input  game_pkg::coord_t vcount,
    input  logic             bright,
    input  logic             btn_left,
    input  logic             btn_right,
    input  logic             btn_jump,
    output game_pkg::color_t rgb,
    output game_pkg::score_t score,
    output game_pkg::coord_t player_x,
    output game_pkg::coord_t player_y
);

    // collision queries back to motion
    logic blocked_left;
    logic blocked_right;
    logic supported;
    logic headbutt;
    game_pkg::coord_t support_y;

    // scene layer hits for the scanned pixel
    logic plat_hit;
    logic coin_hit;

    platform_map i_platform_map (
        .player_x      (player_x),
        .player_y      (player_y),
        .hcount        (hcount),
        .vcount        (vcount),
        .blocked_left  (blocked_left),
        .blocked_right (blocked_right),
        .supported     (supported),
        .headbutt      (headbutt),
        .plat_hit      (plat_hit),
        .support_y     (support_y)
    );

    player_motion #(
        .move_div (move_div),
        .phys_div (phys_div)
    ) i_player_motion (
        .clk           (clk),
        .rst           (rst),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .btn_jump      (btn_jump),
        .blocked_left  (blocked_left),
        .blocked_right (blocked_right),
        .supported     (supported),
        .headbutt      (headbutt),
        .support_y     (support_y),
        .player_x      (player_x),
        .player_y      (player_y)
    );

    coin_tracker i_coin_tracker (
        .clk       (clk),
        .rst       (rst),
        .player_x  (player_x),
        .player_y  (player_y),
        .hcount    (hcount),
        .vcount    (vcount),
        .score     (score),
        .collected (),
        .coin_hit  (coin_hit)
    );

    pixel_compositor i_pixel_compositor (
        .clk      (clk),
        .rst      (rst),
        .hcount   (hcount),
        .vcount   (vcount),
        .bright   (bright),
        .player_x (player_x),
        .player_y (player_y),
        .plat_hit (plat_hit),
        .coin_hit (coin_hit),
        .rgb      (rgb)
    );

endmodule

// ==== logic/player_motion.sv ====
/* player movement: tick dividers, walking with edge and side limits,
   and the jump and gravity state machine */
`timescale 1ns/1ps
`include "game_macros.svh"

module player_motion #(
    parameter int move_div = 500000,
    parameter int phys_div = 1000000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             btn_left,
    input  logic             btn_right,
    input  logic             btn_jump,
    input  logic             blocked_left,
    input  logic             blocked_right,
    input  logic             supported,
    input  logic             headbutt,
    input  game_pkg::coord_t support_y,
    output game_pkg::coord_t player_x,
    output game_pkg::coord_t player_y
);

    localparam int MOVE_W = $clog2(move_div + 1);
    localparam int PHYS_W = $clog2(phys_div + 1);

    logic [MOVE_W-1:0] move_cnt;
    logic [PHYS_W-1:0] phys_cnt;
    logic move_tick;
    logic phys_tick;

    game_pkg::velocity_t vel;
    logic airborne;
    // right edge, one bit wider
    logic [10:0] right_edge;

    // free-running dividers, tick on the last count
    assign move_tick = move_cnt == MOVE_W'(move_div - 1);
    assign phys_tick = phys_cnt == PHYS_W'(phys_div - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            move_cnt <= '0;
            phys_cnt <= '0;
        end else begin
            move_cnt <= move_tick ? '0 : move_cnt + 1'b1;
            phys_cnt <= phys_tick ? '0 : phys_cnt + 1'b1;
        end
    end

    assign right_edge = {1'b0, player_x} + `CHAR_WIDTH;

    // walking, left has priority over right
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            player_x <= `START_X;
        end else if (move_tick) begin
            if (btn_left) begin
                if ((player_x > `SCREEN_LEFT) && !blocked_left)
                    player_x <= player_x - 10'd1;
            end else if (btn_right) begin
                if ((right_edge < `SCREEN_RIGHT) && !blocked_right)
                    player_x <= player_x + 10'd1;
            end
        end
    end

    // vertical rule, applied once per physics tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            player_y <= `GROUND_STAND_Y;
            vel      <= '0;
            airborne <= 1'b0;
        end else if (phys_tick) begin
            if (airborne) begin
                if ((vel < 0) && headbutt) begin
                    // head hit a tile, stop rising
                    vel <= '0;
                end else if ((vel > 0) && supported) begin
                    // landed, snap feet onto the surface
                    player_y <= support_y;
                    vel      <= '0;
                    airborne <= 1'b0;
                end else begin
                    player_y <= player_y + {{3{vel[6]}}, vel};
                    vel      <= vel + `GRAVITY;
                end
            end else if (!supported) begin
                // walked off an edge
                airborne <= 1'b1;
                vel      <= 7'sd1;
            end else if (btn_jump) begin
                airborne <= 1'b1;
                vel      <= -game_pkg::velocity_t'(`V_INIT);
            end
        end
    end

    a_x_in_bounds: assert property (@(posedge clk) disable iff (rst)
        (player_x >= `SCREEN_LEFT) && (right_edge <= {1'b0, `SCREEN_RIGHT}));

endmodule

// ==== project.f ====
+incdir+logic
logic/game_pkg.sv
logic/platform_map.sv
logic/player_motion.sv
logic/coin_tracker.sv
logic/pixel_compositor.sv
logic/platformer_top.sv
test/platformer_tb.sv

// ==== test/platformer_tb.sv ====
/* platformer engine testbench
   reference model stepped every clock and compared on the falling edge */
`timescale 1ns/1ps
`include "game_macros.svh"

module platformer_tb;

    localparam int MOVE_DIV     = 4;
    localparam int PHYS_DIV     = 8;
    localparam int CLK_HALF     = 4;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 3;
    localparam int STAND_Y      = `GROUND_TOP - `CHAR_HEIGHT;
    localparam int SCAN_PIXELS  = 400;
    // pixels walked in all tests and four jumps of at most 40 physics ticks
    localparam int WALK_TICKS   = 814;
    localparam int JUMP_TICKS   = 4 * 40;
    localparam int TEST_CYCLES  = RESET_CYCLES + WALK_TICKS * MOVE_DIV +
                                  JUMP_TICKS * PHYS_DIV + SCAN_PIXELS + 64;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    localparam int PLAT_X0 [`NUM_PLATFORMS] = '{`PLAT0_X0, `PLAT1_X0, `PLAT2_X0, `PLAT3_X0};
    localparam int PLAT_X1 [`NUM_PLATFORMS] = '{`PLAT0_X1, `PLAT1_X1, `PLAT2_X1, `PLAT3_X1};
    localparam int PLAT_Y  [`NUM_PLATFORMS] = '{`PLAT0_Y, `PLAT1_Y, `PLAT2_Y, `PLAT3_Y};
    localparam int COIN_X  [`NUM_COINS] = '{`COIN0_X, `COIN1_X, `COIN2_X, `COIN3_X};
    localparam int COIN_Y  [`NUM_COINS] = '{`COIN0_Y, `COIN1_Y, `COIN2_Y, `COIN3_Y};

    typedef struct packed {
        game_pkg::coord_t     x;
        game_pkg::coord_t     y;
        game_pkg::velocity_t  vel;
        logic                 air;
        game_pkg::coin_mask_t coins;
        game_pkg::score_t     score;
    } game_state_t;

    logic clk, rst, bright, btn_left, btn_right, btn_jump;
    game_pkg::coord_t hcount, vcount, player_x, player_y;
    game_pkg::color_t rgb;
    game_pkg::score_t score;

    // reference state and expected pixel pipeline
    game_state_t ref_s;
    game_pkg::color_t pipe_rgb, exp_rgb;
    int move_cnt, phys_cnt;
    int mismatch_count = 0;
    int fail_count = 0;
    int cycle_count = 0;
    integer seed = 51356;

    platformer_top #(
        .move_div (MOVE_DIV),
        .phys_div (PHYS_DIV)
    ) i_platformer_top (
        .clk       (clk),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .bright    (bright),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .rgb       (rgb),
        .score     (score),
        .player_x  (player_x),
        .player_y  (player_y)
    );

    always #CLK_HALF clk = ~clk;

    // player edge strictly inside the platform span
    function automatic logic spans_platform(input int left, input int i);
        int right;
        right = left + `CHAR_WIDTH;
        return ((right > PLAT_X0[i]) && (right < PLAT_X1[i])) ||
               ((left > PLAT_X0[i]) && (left < PLAT_X1[i]));
    endfunction

    // one clock of the game rules where the ticks pick which rules apply
    function automatic game_state_t game_step(input game_state_t s, input logic move_tick,
            input logic phys_tick, input logic left, input logic right, input logic jump);
        game_state_t n;
        int x, y, bottom, stand_y, plat_stand, touched;
        logic blk_l, blk_r, on_plat, head, sup;
        n = s;
        x = int'(s.x);
        y = int'(s.y);
        bottom = y + `CHAR_HEIGHT;
        blk_l = 1'b0;
        blk_r = 1'b0;
        on_plat = 1'b0;
        head = 1'b0;
        plat_stand = 0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            // side probes only when body rows meet the tile rows
            if ((bottom > PLAT_Y[i]) && (y < PLAT_Y[i] + `TILE_SIZE)) begin
                blk_l |= spans_platform(x - 1, i);
                blk_r |= spans_platform(x + 1, i);
            end
            if (spans_platform(x, i)) begin
                if ((bottom >= PLAT_Y[i]) && (bottom <= PLAT_Y[i] + `STAND_TOL)) begin
                    on_plat = 1'b1;
                    plat_stand = PLAT_Y[i] - `CHAR_HEIGHT;
                end
                if ((y > PLAT_Y[i]) && (y <= PLAT_Y[i] + `TILE_SIZE))
                    head = 1'b1;
            end
        end
        sup = (bottom >= `GROUND_TOP) || on_plat;
        stand_y = (bottom >= `GROUND_TOP) ? STAND_Y : plat_stand;
        if (move_tick) begin
            if (left) begin
                if ((x > `SCREEN_LEFT) && !blk_l)
                    n.x = game_pkg::coord_t'(x - 1);
            end else if (right) begin
                if ((x + `CHAR_WIDTH < `SCREEN_RIGHT) && !blk_r)
                    n.x = game_pkg::coord_t'(x + 1);
            end
        end
        if (phys_tick) begin
            if (s.air) begin
                if ((s.vel < 0) && head) begin
                    n.vel = '0;
                end else if ((s.vel > 0) && sup) begin
                    n.y = game_pkg::coord_t'(stand_y);
                    n.vel = '0;
                    n.air = 1'b0;
                end else begin
                    n.y = game_pkg::coord_t'(y + int'(s.vel));
                    n.vel = game_pkg::velocity_t'(int'(s.vel) + int'(`GRAVITY));
                end
            end else if (!sup) begin
                n.air = 1'b1;
                n.vel = game_pkg::velocity_t'(1);
            end else if (jump) begin
                n.air = 1'b1;
                n.vel = game_pkg::velocity_t'(-int'(`V_INIT));
            end
        end
        // coins use the position before this edge
        touched = 0;
        for (int i = 0; i < `NUM_COINS; i++) begin
            if (!s.coins[i] && (x + `CHAR_WIDTH > COIN_X[i]) && (x < COIN_X[i] + `COIN_SIZE) &&
                (bottom > COIN_Y[i]) && (y < COIN_Y[i] + `COIN_SIZE)) begin
                n.coins[i] = 1'b1;
                touched++;
            end
        end
        n.score = s.score + game_pkg::score_t'(touched);
        return n;
    endfunction

    // layer priority from front to back
    function automatic game_pkg::color_t scene_colour(input int h, input int v, input logic on,
            input int px, input int py, input game_pkg::coin_mask_t coins);
        logic on_plat, on_coin;
        on_plat = 1'b0;
        on_coin = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++)
            if ((h >= PLAT_X0[i]) && (h < PLAT_X1[i]) &&
                (v >= PLAT_Y[i]) && (v < PLAT_Y[i] + `TILE_SIZE))
                on_plat = 1'b1;
        for (int i = 0; i < `NUM_COINS; i++)
            if (!coins[i] && (h >= COIN_X[i]) && (h < COIN_X[i] + `COIN_SIZE) &&
                (v >= COIN_Y[i]) && (v < COIN_Y[i] + `COIN_SIZE))
                on_coin = 1'b1;
        if (!on)
            return `COLOR_BLACK;
        if ((h >= px) && (h < px + `CHAR_WIDTH) && (v >= py) && (v < py + `CHAR_HEIGHT))
            return `COLOR_PLAYER;
        if ((v >= `GROUND_TOP) && (v <= `GROUND_BOTTOM))
            return `COLOR_GROUND;
        if (on_plat)
            return `COLOR_PLATFORM;
        if (on_coin)
            return `COLOR_COIN;
        return `COLOR_SKY;
    endfunction

    task automatic check_coord(input string name, input game_pkg::coord_t got,
            input game_pkg::coord_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input game_pkg::score_t got,
            input game_pkg::score_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input game_pkg::color_t got,
            input game_pkg::color_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // reference steps on the same edge as the DUT
    always @(posedge clk) begin
        if (rst) begin
            ref_s = '0;
            ref_s.x = `START_X;
            ref_s.y = game_pkg::coord_t'(STAND_Y);
            move_cnt = 0;
            phys_cnt = 0;
            pipe_rgb = `COLOR_BLACK;
            exp_rgb = `COLOR_BLACK;
        end else begin
            exp_rgb = pipe_rgb;
            pipe_rgb = scene_colour(int'(hcount), int'(vcount), bright,
                                    int'(ref_s.x), int'(ref_s.y), ref_s.coins);
            ref_s = game_step(ref_s, move_cnt == MOVE_DIV - 1, phys_cnt == PHYS_DIV - 1,
                              btn_left, btn_right, btn_jump);
            move_cnt = (move_cnt == MOVE_DIV - 1) ? 0 : move_cnt + 1;
            phys_cnt = (phys_cnt == PHYS_DIV - 1) ? 0 : phys_cnt + 1;
        end
    end

    // compare every cycle once outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            check_coord("player_x", player_x, ref_s.x);
            check_coord("player_y", player_y, ref_s.y);
            check_score("score", score, ref_s.score);
            check_color("rgb", rgb, exp_rgb);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic hold_buttons(input logic left, input logic right, input logic jump);
        @(posedge clk);
        #DRIVE_DLY;
        btn_left = left;
        btn_right = right;
        btn_jump = jump;
    endtask

    // buttons seen on exactly ticks * MOVE_DIV edges
    task automatic hold_for_ticks(input logic left, input logic right, input int ticks);
        hold_buttons(left, right, 1'b0);
        repeat (ticks * MOVE_DIV - 1) @(posedge clk);
        hold_buttons(1'b0, 1'b0, 1'b0);
        @(negedge clk);
    endtask

    task automatic walk_to(input int target);
        if (target > int'(player_x))
            hold_buttons(1'b0, 1'b1, 1'b0);
        else
            hold_buttons(1'b1, 1'b0, 1'b0);
        while (int'(player_x) != target)
            @(negedge clk);
        hold_buttons(1'b0, 1'b0, 1'b0);
    endtask

    // jump and track the highest row reached until the landing tick
    task automatic jump_and_land(output int peak);
        peak = STAND_Y;
        hold_buttons(1'b0, 1'b0, 1'b1);
        while (int'(player_y) >= STAND_Y)
            @(negedge clk);
        hold_buttons(1'b0, 1'b0, 1'b0);
        while (int'(player_y) != STAND_Y) begin
            @(negedge clk);
            if (int'(player_y) < peak)
                peak = int'(player_y);
        end
        repeat (2 * PHYS_DIV) @(posedge clk);
        @(negedge clk);
        check_coord("landed player_y", player_y, game_pkg::coord_t'(STAND_Y));
    endtask

    // apex of an unobstructed jump as gravity eats the upward speed
    function automatic int free_jump_peak(input int start_y);
        int y;
        y = start_y;
        for (int v = int'(`V_INIT); v > 0; v -= int'(`GRAVITY))
            y = y - v;
        return y;
    endfunction

    // biased toward each layer so every colour shows up
    task automatic random_scan(input int count);
        int r, h, v, i;
        for (int k = 0; k < count; k++) begin
            r = $random(seed);
            i = (r >> 8) & 3;
            h = ((r >> 12) & 63) - 16;
            v = ((r >> 18) & 63) - 16;
            case ((r & 32'h7fff_ffff) % 6)
                0: begin
                    h += int'(player_x);
                    v += int'(player_y);
                end
                1: begin
                    h = (r >> 4) & 1023;
                    v += `GROUND_TOP;
                end
                2: begin
                    h += PLAT_X0[i];
                    v += PLAT_Y[i];
                end
                3: begin
                    h += COIN_X[i];
                    v += COIN_Y[i];
                end
                default: begin
                    h = (r >> 4) & 1023;
                    v = (r >> 14) & 1023;
                end
            endcase
            @(posedge clk);
            #DRIVE_DLY;
            hcount = game_pkg::coord_t'(h);
            vcount = game_pkg::coord_t'(v);
            bright = ((r >> 24) & 7) != 0;
        end
    endtask

    task automatic probe_pixel(input int h, input int v, input game_pkg::color_t exp);
        @(posedge clk);
        #DRIVE_DLY;
        hcount = game_pkg::coord_t'(h);
        vcount = game_pkg::coord_t'(v);
        bright = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_color("probe rgb", rgb, exp);
    endtask

    initial begin
        int peak;
        clk = 1'b0;
        rst = 1'b1;
        hcount = '0;
        vcount = '0;
        bright = 1'b0;
        btn_left = 1'b0;
        btn_right = 1'b0;
        btn_jump = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(negedge clk);
        check_coord("reset player_x", player_x, `START_X);
        check_coord("reset player_y", player_y, game_pkg::coord_t'(STAND_Y));
        check_score("reset score", score, '0);

        // N move ticks right and then pinned against the right limit
        hold_for_ticks(1'b0, 1'b1, 20);
        check_coord("walk right x", player_x, `START_X + 10'd20);
        walk_to(`SCREEN_RIGHT - `CHAR_WIDTH);
        hold_for_ticks(1'b0, 1'b1, 10);
        check_coord("right limit x", player_x, `SCREEN_RIGHT - `CHAR_WIDTH);
        hold_for_ticks(1'b1, 1'b0, 20);
        check_coord("walk left x", player_x, `SCREEN_RIGHT - `CHAR_WIDTH - 10'd20);

        // open-sky jump
        jump_and_land(peak);
        check_coord("jump peak y", game_pkg::coord_t'(peak),
                    game_pkg::coord_t'(free_jump_peak(STAND_Y)));

        // jump under platform 3 stops with the head inside the tile
        walk_to(380);
        jump_and_land(peak);
        if (!((peak > `PLAT3_Y) && (peak <= `PLAT3_Y + `TILE_SIZE))) begin
            fail_count++;
            $display("jump under platform 3 did not stop at its underside, top reached %0d",
                     peak);
        end

        // coin 0 is collected once only
        walk_to(300);
        jump_and_land(peak);
        check_score("score after coin", score, 16'd1);
        jump_and_land(peak);
        check_score("score after repeat", score, 16'd1);

        random_scan(SCAN_PIXELS);
        probe_pixel(316, 476, `COLOR_PLAYER);
        probe_pixel(160, 505, `COLOR_GROUND);
        probe_pixel(520, 410, `COLOR_PLATFORM);
        probe_pixel(608, 390, `COLOR_COIN);
        probe_pixel(308, 408, `COLOR_SKY);
        probe_pixel(200, 100, `COLOR_SKY);

        $display("run complete: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        if ((mismatch_count == 0) && (fail_count == 0))
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
